/* Makefile */
# Verilator build for the bit-manipulation control unit testbench.
# Every variable below can be overridden on the make command line.

VERILATOR ?= verilator
TOP       ?= bmuCtrlTb
FILELIST  ?= bmuCtrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= *** PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := common/bmu_params.svh
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(EXE) | tee $(LOG)
	grep -qxF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bmuCtrl.f */
+incdir+common
common/bmuPkg.sv
decode/zbbDecode.sv
decode/bmuDecode.sv
verilog/bmuIssue.sv
verilog/bmuCtrl.sv
verification/bmuCtrl_checker.sv
verification/bmuCtrlTb.sv

/* common/bmuPkg.sv */
// Shared types for the bit-manipulation decode unit.
// The instruction word is a packed union so one 32-bit value can be
// read as an R-type word or as a shift-immediate word with a 6-bit shamt.
// Modules pull the types in with a wildcard import in their header.

`default_nettype none

package bmuPkg;

  // R-type view, also used for the rs2-qualified unary rows
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeT;

  // shift-immediate view
  // shamt[5] overlays funct7[0] of the R-type view
  typedef struct packed {
    logic [5:0] funct6;
    logic [5:0] shamt;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } shiftImmT;

  // one instruction word with two decodings
  typedef union packed {
    rTypeT    r;                                  // funct7 / rs2 view
    shiftImmT sh;                                 // funct6 / shamt view
  } instrWordT;

endpackage

`default_nettype wire

/* common/bmu_params.svh */
// Configuration macros for the bit-manipulation decode unit.
// Include this header in any RTL file that needs the datapath width,
// the extension switches, the major opcodes or the control-field widths.
// Change the values here to build an rv32 or rv64 core with a subset
// of Zba, Zbb and Zbs.

`ifndef BMU_PARAMS_SVH
`define BMU_PARAMS_SVH

// datapath width, 32 or 64
`define BMU_XLEN 64

// extension switches, 1 enables the table rows
`define BMU_ZBA_SUPPORTED 1
`define BMU_ZBB_SUPPORTED 1
`define BMU_ZBS_SUPPORTED 1

// major opcodes seen by the bit-manipulation tables
`define OP_REG   7'b0110011
`define OP_IMM   7'b0010011
`define OP_REG_W 7'b0111011
`define OP_IMM_W 7'b0011011

// control field widths
`define ALU_SELECT_W 3
`define BSELECT_W    4
`define ZBB_SELECT_W 4
`define BALU_CTRL_W  3

`endif

/* decode/bmuDecode.sv */
// Decode-stage table for the bit-manipulation unit.
// Matches the Zba and Zbs rows here and merges the result of the Zbb
// and base-shift table from zbbDecode, which wins over earlier rows.
// All outputs are combinational from InstrD. With no hit the word is
// flagged illegal and every other field is zero.

`default_nettype none

`include "bmu_params.svh"

module bmuDecode import bmuPkg::*; (
  input  instrWordT                  InstrD,
  output logic                       BRegWriteD,
  output logic                       BALUSrcBD,
  output logic                       BW64D,
  output logic                       BUW64D,
  output logic                       BSubArithD,
  output logic                       IllegalBitmanipInstrD,
  output logic [`ALU_SELECT_W-1:0]   BALUSelectD,
  output logic [`BSELECT_W-1:0]      BSelectD,
  output logic [`ZBB_SELECT_W-1:0]   ZBBSelectD,
  output logic                       BALUOpD,
  output logic                       RotateD,
  output logic                       MaskD,
  output logic                       PreShiftD,
  output logic [2:0]                 Funct3D
);

  // aluSel_bSel_zbbSel_regWr_srcB_w64_uw64_aluOp_subArith_rot_mask_preShift_illegal
  localparam int CtrlW = `ALU_SELECT_W + `BSELECT_W + `ZBB_SELECT_W + 10;

  logic [CtrlW-1:0]          ctrlD;               // packed decode row
  logic [6:0]                opD;
  logic                      zbbHit;              // zbb or base shift matched
  logic [`ALU_SELECT_W-1:0]  zbbAluSel;
  logic [`BSELECT_W-1:0]     zbbBSel;
  logic [`ZBB_SELECT_W-1:0]  zbbSel;
  logic                      zbbSrcB;
  logic                      zbbW64;
  logic                      zbbSubArith;
  logic                      zbbRotate;
  logic                      countWord;           // clzw / ctzw / cpopw

  // zbs rows share everything but the select, subArith and srcB
  function automatic logic [CtrlW-1:0] zbsRow(input logic [2:0] sel,
                                              input logic       subArith,
                                              input logic       srcB);
    zbsRow = {sel, 4'b0001, 4'b0000, 1'b1, srcB, 2'b00, 1'b1, subArith,
              1'b0, 1'b1, 1'b0, 1'b0};
  endfunction

  assign opD     = InstrD.r.opcode;
  assign Funct3D = InstrD.r.funct3;

  zbbDecode zbbTable (
    .InstrD       (InstrD),
    .ZbbHit       (zbbHit),
    .ZbbALUSelect (zbbAluSel),
    .ZbbBSelect   (zbbBSel),
    .ZbbSelect    (zbbSel),
    .ZbbSrcB      (zbbSrcB),
    .ZbbW64       (zbbW64),
    .ZbbSubArith  (zbbSubArith),
    .ZbbRotate    (zbbRotate)
  );

  // only the count-word row is a W form in the unary group
  assign countWord = zbbHit & zbbW64 & (zbbBSel == 4'b0010);

  ////////////////////////////////////////////////////////////
  // decode table
  ////////////////////////////////////////////////////////////
  always_comb begin
    ctrlD = {{(CtrlW-1){1'b0}}, 1'b1};            // default illegal

    if (`BMU_ZBA_SUPPORTED) begin
      if (opD == `OP_REG)
        case ({InstrD.r.funct7, Funct3D})
          10'b0010000_010, 10'b0010000_100, 10'b0010000_110:
            ctrlD = 21'b000_0001_0000_1_0_0_0_1_0_0_0_1_0;  // shNadd
          default: ;
        endcase
      if (`BMU_XLEN == 64) begin
        if (opD == `OP_REG_W)
          case ({InstrD.r.funct7, Funct3D})
            10'b0010000_010, 10'b0010000_100, 10'b0010000_110:
              ctrlD = 21'b000_0001_0000_1_0_0_1_1_0_0_0_1_0;  // shNadd.uw
            10'b0000100_000:
              ctrlD = 21'b000_0001_0000_1_0_0_1_1_0_0_0_0_0;  // add.uw, no preshift
            default: ;
          endcase
        if (opD == `OP_IMM_W && InstrD.sh.funct6 == 6'b000010 && Funct3D == 3'b001)
          ctrlD = 21'b001_0001_0000_1_1_0_1_1_0_0_0_0_0;      // slli.uw on shifter
      end
    end

    if (`BMU_ZBS_SUPPORTED) begin
      if (opD == `OP_REG)
        case ({InstrD.r.funct7, Funct3D})
          10'b0100100_001: ctrlD = zbsRow(3'b111, 1'b1, 1'b0);  // bclr
          10'b0100100_101: ctrlD = zbsRow(3'b101, 1'b0, 1'b0);  // bext
          10'b0110100_001: ctrlD = zbsRow(3'b100, 1'b0, 1'b0);  // binv
          10'b0010100_001: ctrlD = zbsRow(3'b110, 1'b0, 1'b0);  // bset
          default: ;
        endcase
      // rv32 index must stay below 32
      if (opD == `OP_IMM && (`BMU_XLEN == 64 || !InstrD.sh.shamt[5]))
        case ({InstrD.sh.funct6, Funct3D})
          9'b010010_001: ctrlD = zbsRow(3'b111, 1'b1, 1'b1);    // bclri
          9'b010010_101: ctrlD = zbsRow(3'b101, 1'b0, 1'b1);    // bexti
          9'b011010_001: ctrlD = zbsRow(3'b100, 1'b0, 1'b1);    // binvi
          9'b001010_001: ctrlD = zbsRow(3'b110, 1'b0, 1'b1);    // bseti
          default: ;
        endcase
    end

    // zbb and base shifts override earlier rows
    if (zbbHit)
      ctrlD = {zbbAluSel, zbbBSel, zbbSel, 1'b1, zbbSrcB, zbbW64, countWord,
               ~countWord, zbbSubArith, zbbRotate, 3'b000};
  end

  assign {BALUSelectD, BSelectD, ZBBSelectD, BRegWriteD, BALUSrcBD, BW64D, BUW64D,
          BALUOpD, BSubArithD, RotateD, MaskD, PreShiftD, IllegalBitmanipInstrD} = ctrlD;

endmodule

`default_nettype wire

/* decode/zbbDecode.sv */
// Zbb decode table plus the base shifts that run on the shared shifter.
// Reports a hit flag and the select and flag fields of the matching row.
// The unary rows are qualified by the rs2 field of the R-type view and
// the immediate rotates and shifts by the funct6 / shamt view.
// Purely combinational. Without a hit every output is zero.

`default_nettype none

`include "bmu_params.svh"

module zbbDecode import bmuPkg::*; (
  input  instrWordT                  InstrD,
  output logic                       ZbbHit,
  output logic [`ALU_SELECT_W-1:0]   ZbbALUSelect,
  output logic [`BSELECT_W-1:0]      ZbbBSelect,
  output logic [`ZBB_SELECT_W-1:0]   ZbbSelect,
  output logic                       ZbbSrcB,
  output logic                       ZbbW64,
  output logic                       ZbbSubArith,
  output logic                       ZbbRotate
);

  // hit_aluSel_bSel_zbbSel_srcB_w64_subArith_rotate
  localparam int RowW = 1 + `ALU_SELECT_W + `BSELECT_W + `ZBB_SELECT_W + 4;
  // rev8 shamt differs with xlen
  localparam logic [5:0] Rev8Shamt = (`BMU_XLEN == 64) ? 6'b111000 : 6'b011000;

  logic [RowW-1:0] zbbRow;
  logic [6:0]      opD;
  logic [2:0]      funct3D;
  logic [4:0]      rs2D;
  logic            immShiftOk;                    // rv32 shamt below 32

  assign opD        = InstrD.r.opcode;
  assign funct3D    = InstrD.r.funct3;
  assign rs2D       = InstrD.r.rs2;
  assign immShiftOk = (`BMU_XLEN == 64) || !InstrD.sh.shamt[5];

  always_comb begin
    zbbRow = '0;                                  // no hit

    if (`BMU_ZBB_SUPPORTED) begin
      case (opD)
        `OP_IMM: begin
          if (InstrD.r.funct7 == 7'b0110000 && funct3D == 3'b001) begin
            if (rs2D[4:1] == 4'b0010)
              zbbRow = 16'b1_000_0010_0001_1_0_0_0;             // sext.b / sext.h
            else if (rs2D <= 5'd2)
              zbbRow = 16'b1_000_0010_0000_1_0_0_0;             // clz / ctz / cpop
          end
          if (InstrD.r.funct7 == 7'b0010100 && funct3D == 3'b101 && rs2D == 5'b00111)
            zbbRow = 16'b1_000_0010_0010_1_0_0_0;               // orc.b
          if (InstrD.sh.funct6 == 6'b011010 && funct3D == 3'b101 &&
              InstrD.sh.shamt == Rev8Shamt)
            zbbRow = 16'b1_000_0010_0010_1_0_0_0;               // rev8
          if (InstrD.sh.funct6 == 6'b011000 && funct3D == 3'b101 && immShiftOk)
            zbbRow = 16'b1_001_0000_0111_1_0_0_1;               // rori
        end
        `OP_REG:
          case ({InstrD.r.funct7, funct3D})
            10'b0000101_110, 10'b0000101_111:
              zbbRow = 16'b1_000_0010_0111_0_0_1_0;             // max / maxu
            10'b0000101_100, 10'b0000101_101:
              zbbRow = 16'b1_000_0010_0011_0_0_1_0;             // min / minu
            10'b0110000_001, 10'b0110000_101:
              zbbRow = 16'b1_001_0001_0111_0_0_0_1;             // rol / ror
            10'b0100000_111: zbbRow = 16'b1_111_0001_0111_0_0_1_0;  // andn
            10'b0100000_110: zbbRow = 16'b1_110_0001_0111_0_0_1_0;  // orn
            10'b0100000_100: zbbRow = 16'b1_100_0001_0111_0_0_1_0;  // xnor
            10'b0000100_100:
              if (`BMU_XLEN == 32)
                zbbRow = 16'b1_000_0010_0001_1_0_0_0;           // zext.h rv32 form
            default: ;
          endcase
        `OP_REG_W:
          if (`BMU_XLEN == 64)
            case ({InstrD.r.funct7, funct3D})
              10'b0000100_100: zbbRow = 16'b1_000_0010_0001_0_0_0_0;  // zext.h
              10'b0110000_001, 10'b0110000_101:
                zbbRow = 16'b1_001_0000_0111_0_1_0_1;           // rolw / rorw
              default: ;
            endcase
        `OP_IMM_W:
          if (`BMU_XLEN == 64) begin
            if (InstrD.r.funct7 == 7'b0110000 && funct3D == 3'b001 && rs2D <= 5'd2)
              zbbRow = 16'b1_000_0010_0000_1_1_0_0;             // clzw / ctzw / cpopw
            if (InstrD.r.funct7 == 7'b0110000 && funct3D == 3'b101)
              zbbRow = 16'b1_001_0000_0111_1_1_0_1;             // roriw
          end
        default: ;
      endcase
    end

    ////////////////////////////////////////////////////////////
    // base shifts on the shared shifter
    ////////////////////////////////////////////////////////////
    if (`BMU_ZBB_SUPPORTED || `BMU_ZBS_SUPPORTED) begin
      if (funct3D[1:0] == 2'b01) begin
        if (opD == `OP_REG && {InstrD.r.funct7[6], InstrD.r.funct7[4:0]} == 6'b0)
          zbbRow = 16'b1_001_0000_0000_0_0_0_0;                 // sll / srl / sra
        if (opD == `OP_IMM && {InstrD.sh.funct6[5], InstrD.sh.funct6[3:0]} == 5'b0 &&
            immShiftOk)
          zbbRow = 16'b1_001_0000_0000_1_0_0_0;                 // slli / srli / srai
        if (`BMU_XLEN == 64 && {InstrD.r.funct7[6], InstrD.r.funct7[4:0]} == 6'b0) begin
          if (opD == `OP_REG_W)
            zbbRow = 16'b1_001_0000_0000_0_1_0_0;               // sllw / srlw / sraw
          if (opD == `OP_IMM_W)
            zbbRow = 16'b1_001_0000_0000_1_1_0_0;               // slliw / srliw / sraiw
        end
      end
    end
  end

  assign {ZbbHit, ZbbALUSelect, ZbbBSelect, ZbbSelect, ZbbSrcB, ZbbW64,
          ZbbSubArith, ZbbRotate} = zbbRow;

endmodule

`default_nettype wire

/* verification/bmuCtrlTb.sv */
// Table-driven testbench for the bit-manipulation control unit.
// Each row drives one Decode word with ALUOpD, StallE and FlushE, checks
// the Decode outputs in the same cycle and the Execute outputs one cycle
// later against a model register. Built for rv64 with Zba, Zbb and Zbs.

`default_nettype none

`include "bmu_params.svh"

module bmuCtrlTb import bmuPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MaxRows = 64;
  localparam logic [6:0] OpR  = `OP_REG;
  localparam logic [6:0] OpI  = `OP_IMM;
  localparam logic [6:0] OpRW = `OP_REG_W;
  localparam logic [6:0] OpIW = `OP_IMM_W;

  logic                      clk;
  logic                      reset;
  instrWordT                 instrD;
  logic                      aluOpD;
  logic                      stallE;
  logic                      flushE;
  logic                      bRegWriteD;
  logic                      bAluSrcBD;
  logic                      bW64D;
  logic                      bUW64D;
  logic                      bSubArithD;
  logic                      illegalD;
  logic [`ALU_SELECT_W-1:0]  aluSelectD;
  logic [`BSELECT_W-1:0]     bSelectE;
  logic [`ZBB_SELECT_W-1:0]  zbbSelectE;
  logic [`BALU_CTRL_W-1:0]   baluControlE;
  logic                      bmuActiveE;

  // stimulus table
  logic [31:0] rowInstr [MaxRows];
  logic [2:0]  rowCtl   [MaxRows];                // aluOp, stall, flush
  logic [19:0] rowExp   [MaxRows];                // expected decode word
  int          rowGroup [MaxRows];
  int          rowCount;
  int          tableGroup;
  string       groupName [1:5];
  int          groupErrors [1:5];
  int          curGroup;
  int          checkCount;
  int          errorCount;
  int          testsPassed;
  int          testsFailed;
  int          cycles;
  logic [11:0] expE;                              // model of execute register

  bmuCtrl DUT (
    .clk (clk), .reset (reset), .InstrD (instrD), .ALUOpD (aluOpD),
    .StallE (stallE), .FlushE (flushE),
    .BRegWriteD (bRegWriteD), .BALUSrcBD (bAluSrcBD), .BW64D (bW64D),
    .BUW64D (bUW64D), .BSubArithD (bSubArithD), .IllegalBitmanipInstrD (illegalD),
    .ALUSelectD (aluSelectD), .BSelectE (bSelectE), .ZBBSelectE (zbbSelectE),
    .BALUControlE (baluControlE), .BMUActiveE (bmuActiveE)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;                           // 8 ns period

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= 2 * rowCount + 20) begin        // table length plus margin
      $display("Timeout: the run did not finish within %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] rEnc(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [2:0] f3, input logic [6:0] op);
    rEnc = {f7, rs2, 5'd3, f3, 5'd2, op};         // rs1 x3, rd x2
  endfunction

  function automatic logic [31:0] iEnc(input logic [5:0] f6, input logic [5:0] shamt,
                                       input logic [2:0] f3, input logic [6:0] op);
    iEnc = {f6, shamt, 5'd3, f3, 5'd2, op};
  endfunction

  task automatic addRow(input logic [31:0] instr, input logic [2:0] ctl,
                        input logic [19:0] expD);
    rowInstr[rowCount] = instr;
    rowCtl[rowCount]   = ctl;
    rowExp[rowCount]   = expD;
    rowGroup[rowCount] = tableGroup;
    rowCount++;
  endtask

  task automatic checkValue(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      groupErrors[curGroup]++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic checkDecode(input int i);
    logic [19:0] e;
    e = rowExp[i];
    checkValue($sformatf("row %0d BRegWriteD", i), 32'(bRegWriteD), 32'(e[19]));
    checkValue($sformatf("row %0d BALUSrcBD", i), 32'(bAluSrcBD), 32'(e[18]));
    checkValue($sformatf("row %0d BW64D", i), 32'(bW64D), 32'(e[17]));
    checkValue($sformatf("row %0d BUW64D", i), 32'(bUW64D), 32'(e[16]));
    checkValue($sformatf("row %0d BSubArithD", i), 32'(bSubArithD), 32'(e[15]));
    checkValue($sformatf("row %0d IllegalD", i), 32'(illegalD), 32'(e[14]));
    checkValue($sformatf("row %0d ALUSelectD", i), 32'(aluSelectD), 32'(e[13:11]));
  endtask

  task automatic checkExecute(input logic [11:0] e);
    checkValue("BSelectE", 32'(bSelectE), 32'(e[11:8]));
    checkValue("ZBBSelectE", 32'(zbbSelectE), 32'(e[7:4]));
    checkValue("BALUControlE", 32'(baluControlE), 32'(e[3:1]));
    checkValue("BMUActiveE", 32'(bmuActiveE), 32'(e[0]));
  endtask

  task automatic reportGroup(input int g);
    if (groupErrors[g] == 0) begin
      testsPassed++;
      $display("test %0d %s: ok", g, groupName[g]);
    end else begin
      testsFailed++;
      $display("test %0d %s: %0d mismatches", g, groupName[g], groupErrors[g]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table
  // expected word msb first
  // regWr srcB w64 uw64 sub ill _ aluSelect _ bSel _ zbbSel _ rot mask pre
  ////////////////////////////////////////////////////////////
  task automatic fillTable();
    tableGroup = 1;                               // zba
    addRow(rEnc(7'b0010000, 5'd4, 3'b010, OpR), 3'b000, 20'b100000_000_0001_0000_001);
    addRow(rEnc(7'b0010000, 5'd4, 3'b100, OpR), 3'b100, 20'b100000_000_0001_0000_001);
    addRow(rEnc(7'b0010000, 5'd4, 3'b110, OpR), 3'b000, 20'b100000_000_0001_0000_001);
    addRow(rEnc(7'b0010000, 5'd4, 3'b010, OpRW), 3'b000, 20'b100100_000_0001_0000_001);
    addRow(rEnc(7'b0010000, 5'd4, 3'b110, OpRW), 3'b000, 20'b100100_000_0001_0000_001);
    addRow(rEnc(7'b0000100, 5'd4, 3'b000, OpRW), 3'b000, 20'b100100_000_0001_0000_000);
    addRow(iEnc(6'b000010, 6'd5, 3'b001, OpIW), 3'b000, 20'b110100_001_0001_0000_000);
    addRow(iEnc(6'b000010, 6'd33, 3'b001, OpIW), 3'b000, 20'b110100_001_0001_0000_000);
    tableGroup = 2;                               // zbb
    addRow(rEnc(7'b0110000, 5'd0, 3'b001, OpI), 3'b000, 20'b110000_000_0010_0000_000);
    addRow(rEnc(7'b0110000, 5'd2, 3'b001, OpI), 3'b000, 20'b110000_000_0010_0000_000);
    addRow(rEnc(7'b0110000, 5'd4, 3'b001, OpI), 3'b000, 20'b110000_000_0010_0001_000);
    addRow(rEnc(7'b0110000, 5'd3, 3'b001, OpI), 3'b000, 20'b000001_000_0000_0000_000);
    addRow(rEnc(7'b0110000, 5'd6, 3'b001, OpI), 3'b000, 20'b000001_000_0000_0000_000);
    addRow(rEnc(7'b0010100, 5'd7, 3'b101, OpI), 3'b000, 20'b110000_000_0010_0010_000);
    addRow(rEnc(7'b0010100, 5'd6, 3'b101, OpI), 3'b000, 20'b000001_000_0000_0000_000);
    addRow(iEnc(6'b011010, 6'd56, 3'b101, OpI), 3'b000, 20'b110000_000_0010_0010_000);
    addRow(rEnc(7'b0000101, 5'd4, 3'b100, OpR), 3'b000, 20'b100010_000_0010_0011_000);
    addRow(rEnc(7'b0000101, 5'd4, 3'b111, OpR), 3'b000, 20'b100010_000_0010_0111_000);
    addRow(rEnc(7'b0100000, 5'd4, 3'b111, OpR), 3'b000, 20'b100010_111_0001_0111_000);
    addRow(rEnc(7'b0100000, 5'd4, 3'b110, OpR), 3'b000, 20'b100010_110_0001_0111_000);
    addRow(rEnc(7'b0100000, 5'd4, 3'b100, OpR), 3'b000, 20'b100010_100_0001_0111_000);
    addRow(rEnc(7'b0110000, 5'd4, 3'b001, OpR), 3'b000, 20'b100000_001_0001_0111_100);
    addRow(rEnc(7'b0110000, 5'd4, 3'b101, OpR), 3'b000, 20'b100000_001_0001_0111_100);
    addRow(iEnc(6'b011000, 6'd40, 3'b101, OpI), 3'b000, 20'b110000_001_0000_0111_100);
    addRow(rEnc(7'b0110000, 5'd4, 3'b001, OpRW), 3'b000, 20'b101000_001_0000_0111_100);
    addRow(rEnc(7'b0110000, 5'd7, 3'b101, OpIW), 3'b000, 20'b111000_001_0000_0111_100);
    addRow(rEnc(7'b0110000, 5'd0, 3'b001, OpIW), 3'b100, 20'b111100_001_0010_0000_000);
    addRow(rEnc(7'b0000100, 5'd0, 3'b100, OpRW), 3'b000, 20'b100000_000_0010_0001_000);
    tableGroup = 3;                               // zbs
    addRow(rEnc(7'b0100100, 5'd4, 3'b001, OpR), 3'b000, 20'b100010_111_0001_0000_010);
    addRow(rEnc(7'b0100100, 5'd4, 3'b101, OpR), 3'b000, 20'b100000_101_0001_0000_010);
    addRow(rEnc(7'b0110100, 5'd4, 3'b001, OpR), 3'b000, 20'b100000_100_0001_0000_010);
    addRow(rEnc(7'b0010100, 5'd4, 3'b001, OpR), 3'b000, 20'b100000_110_0001_0000_010);
    addRow(iEnc(6'b010010, 6'd33, 3'b001, OpI), 3'b000, 20'b110010_111_0001_0000_010);
    addRow(iEnc(6'b010010, 6'd4, 3'b101, OpI), 3'b000, 20'b110000_101_0001_0000_010);
    addRow(iEnc(6'b011010, 6'd63, 3'b001, OpI), 3'b000, 20'b110000_100_0001_0000_010);
    addRow(iEnc(6'b001010, 6'd10, 3'b001, OpI), 3'b000, 20'b110000_110_0001_0000_010);
    tableGroup = 4;                               // alu select and illegal words
    addRow(rEnc(7'b0000000, 5'd4, 3'b000, OpR), 3'b100, 20'b000001_000_0000_0000_000);
    addRow(rEnc(7'b0000000, 5'd4, 3'b100, OpR), 3'b100, 20'b000001_100_0000_0000_000);
    addRow(rEnc(7'b0000000, 5'd4, 3'b100, OpR), 3'b000, 20'b000001_000_0000_0000_000);
    addRow(rEnc(7'b0000000, 5'd4, 3'b110, OpR), 3'b100, 20'b000001_110_0000_0000_000);
    addRow(rEnc(7'b0000000, 5'd4, 3'b001, OpR), 3'b100, 20'b100000_001_0000_0000_000);
    addRow(rEnc(7'b0100000, 5'd4, 3'b101, OpR), 3'b000, 20'b100000_001_0000_0000_000);
    addRow(iEnc(6'b010000, 6'd35, 3'b101, OpI), 3'b000, 20'b110000_001_0000_0000_000);
    addRow(rEnc(7'b0000000, 5'd4, 3'b001, OpRW), 3'b000, 20'b101000_001_0000_0000_000);
    addRow(rEnc(7'b0000000, 5'd3, 3'b101, OpIW), 3'b000, 20'b111000_001_0000_0000_000);
    addRow(rEnc(7'b0000001, 5'd4, 3'b000, OpR), 3'b000, 20'b000001_000_0000_0000_000);
    addRow(rEnc(7'b0000000, 5'd4, 3'b010, 7'b0000011), 3'b000, 20'b000001_000_0000_0000_000);
    tableGroup = 5;                               // execute register
    addRow(rEnc(7'b0100000, 5'd4, 3'b111, OpR), 3'b000, 20'b100010_111_0001_0111_000);
    addRow(rEnc(7'b0110100, 5'd4, 3'b001, OpR), 3'b010, 20'b100000_100_0001_0000_010);
    addRow(rEnc(7'b0110100, 5'd4, 3'b001, OpR), 3'b011, 20'b100000_100_0001_0000_010);
    addRow(rEnc(7'b0110000, 5'd4, 3'b001, OpR), 3'b001, 20'b100000_001_0001_0111_100);
    addRow(rEnc(7'b0000101, 5'd4, 3'b100, OpR), 3'b000, 20'b100010_000_0010_0011_000);
    addRow(rEnc(7'b0010000, 5'd4, 3'b010, OpR), 3'b000, 20'b100000_000_0001_0000_001);
  endtask

  initial begin
    int i;
    reset = 1'b1;
    instrD = rEnc(7'b0100000, 5'd4, 3'b111, OpR);  // legal andn word while in reset
    aluOpD = 1'b0;
    stallE = 1'b0;
    flushE = 1'b0;
    cycles = 0;
    rowCount = 0;
    checkCount = 0;
    errorCount = 0;
    testsPassed = 0;
    testsFailed = 0;
    groupName[1] = "zba decode";
    groupName[2] = "zbb decode";
    groupName[3] = "zbs decode";
    groupName[4] = "alu select and illegal";
    groupName[5] = "execute register";
    for (i = 1; i <= 5; i++)
      groupErrors[i] = 0;
    fillTable();

    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    instrD = '0;                                  // opcode 0, no bmu row
    curGroup = 5;
    expE = 12'h000;
    checkExecute(expE);                           // cleared by reset

    for (i = 0; i < rowCount; i++) begin
      @(posedge clk);
      #1;
      curGroup = (i == 0) ? 5 : rowGroup[i-1];    // register shows previous row
      checkExecute(expE);
      if (i > 0 && rowGroup[i] != rowGroup[i-1])
        reportGroup(rowGroup[i-1]);
      curGroup = rowGroup[i];
      instrD = rowInstr[i];
      {aluOpD, stallE, flushE} = rowCtl[i];
      #4;
      checkDecode(i);
      if (!rowCtl[i][1])                          // stall holds the model
        expE = rowCtl[i][0] ? 12'h000 : {rowExp[i][10:0], ~rowExp[i][14]};
    end
    @(posedge clk);
    #1;
    curGroup = rowGroup[rowCount-1];
    checkExecute(expE);
    reportGroup(curGroup);

    $display("summary: %0d tests passed, %0d failed, %0d checks, %0d mismatches",
             testsPassed, testsFailed, checkCount, errorCount);
    if (errorCount == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/bmuCtrl_checker.sv */
// Concurrent checks on the Execute-stage control register of the BMU.
// Bound into bmuCtrl, so they watch the register through the top-level
// ports. They cover the reset, stall and flush rules of the register.

`default_nettype none

`include "bmu_params.svh"

module bmuCtrlChecker (
  input logic                       clk,
  input logic                       reset,
  input logic                       StallE,
  input logic                       FlushE,
  input logic [`BSELECT_W-1:0]      BSelectE,
  input logic [`ZBB_SELECT_W-1:0]   ZBBSelectE,
  input logic [`BALU_CTRL_W-1:0]    BALUControlE,
  input logic                       BMUActiveE
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ExeW = `BSELECT_W + `ZBB_SELECT_W + `BALU_CTRL_W + 1;

  logic [ExeW-1:0] exeCtrl;                       // whole execute register

  assign exeCtrl = {BSelectE, ZBBSelectE, BALUControlE, BMUActiveE};

  activeClearedByReset: assert property (@(posedge clk) reset |=> !BMUActiveE)
    else $error("BMUActiveE set in the cycle after reset");

  holdUnderStall: assert property (@(posedge clk) (!reset && StallE) |=> $stable(exeCtrl))
    else $error("execute controls changed while StallE was high");

  // flush only counts when not stalled
  zeroAfterFlush: assert property (@(posedge clk)
      (!reset && !StallE && FlushE) |=> (exeCtrl == '0))
    else $error("execute controls not zero after FlushE");

endmodule

bind bmuCtrl bmuCtrlChecker execChecks (
  .clk          (clk),
  .reset        (reset),
  .StallE       (StallE),
  .FlushE       (FlushE),
  .BSelectE     (BSelectE),
  .ZBBSelectE   (ZBBSelectE),
  .BALUControlE (BALUControlE),
  .BMUActiveE   (BMUActiveE)
);

`default_nettype wire

/* verilog/bmuCtrl.sv */
// Top level of the bit-manipulation control unit.
// Connects the Decode-stage table to the issue logic that forms the
// ALU select and the Execute-stage control register.

`default_nettype none

`include "bmu_params.svh"

module bmuCtrl import bmuPkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  instrWordT                  InstrD,
  input  logic                       ALUOpD,
  input  logic                       StallE,
  input  logic                       FlushE,
  output logic                       BRegWriteD,
  output logic                       BALUSrcBD,
  output logic                       BW64D,
  output logic                       BUW64D,
  output logic                       BSubArithD,
  output logic                       IllegalBitmanipInstrD,
  output logic [`ALU_SELECT_W-1:0]   ALUSelectD,
  output logic [`BSELECT_W-1:0]      BSelectE,
  output logic [`ZBB_SELECT_W-1:0]   ZBBSelectE,
  output logic [`BALU_CTRL_W-1:0]    BALUControlE,
  output logic                       BMUActiveE
);

  logic [`ALU_SELECT_W-1:0]  baluSelectD;
  logic [`BSELECT_W-1:0]     bSelectD;
  logic [`ZBB_SELECT_W-1:0]  zbbSelectD;
  logic                      baluOpD;
  logic                      rotateD;
  logic                      maskD;
  logic                      preShiftD;
  logic [2:0]                funct3D;

  bmuDecode decode (
    .InstrD                (InstrD),
    .BRegWriteD            (BRegWriteD),
    .BALUSrcBD             (BALUSrcBD),
    .BW64D                 (BW64D),
    .BUW64D                (BUW64D),
    .BSubArithD            (BSubArithD),
    .IllegalBitmanipInstrD (IllegalBitmanipInstrD),
    .BALUSelectD           (baluSelectD),
    .BSelectD              (bSelectD),
    .ZBBSelectD            (zbbSelectD),
    .BALUOpD               (baluOpD),
    .RotateD               (rotateD),
    .MaskD                 (maskD),
    .PreShiftD             (preShiftD),
    .Funct3D               (funct3D)
  );

  bmuIssue issue (
    .clk                   (clk),
    .reset                 (reset),
    .StallE                (StallE),
    .FlushE                (FlushE),
    .ALUOpD                (ALUOpD),
    .BALUOpD               (baluOpD),
    .BALUSelectD           (baluSelectD),
    .Funct3D               (funct3D),
    .BSelectD              (bSelectD),
    .ZBBSelectD            (zbbSelectD),
    .RotateD               (rotateD),
    .MaskD                 (maskD),
    .PreShiftD             (preShiftD),
    .IllegalBitmanipInstrD (IllegalBitmanipInstrD),
    .ALUSelectD            (ALUSelectD),
    .BSelectE              (BSelectE),
    .ZBBSelectE            (ZBBSelectE),
    .BALUControlE          (BALUControlE),
    .BMUActiveE            (BMUActiveE)
  );

endmodule

`default_nettype wire

/* verilog/bmuIssue.sv */
// ALU select choice and Execute-stage control register for the BMU.
// ALUSelectD is combinational in Decode. The register captures the
// Decode selects on each clock unless StallE holds it. FlushE clears
// it when not stalled and reset clears it over both.

`default_nettype none

`include "bmu_params.svh"

module bmuIssue import bmuPkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       StallE,
  input  logic                       FlushE,
  input  logic                       ALUOpD,
  input  logic                       BALUOpD,
  input  logic [`ALU_SELECT_W-1:0]   BALUSelectD,
  input  logic [2:0]                 Funct3D,
  input  logic [`BSELECT_W-1:0]      BSelectD,
  input  logic [`ZBB_SELECT_W-1:0]   ZBBSelectD,
  input  logic                       RotateD,
  input  logic                       MaskD,
  input  logic                       PreShiftD,
  input  logic                       IllegalBitmanipInstrD,
  output logic [`ALU_SELECT_W-1:0]   ALUSelectD,
  output logic [`BSELECT_W-1:0]      BSelectE,
  output logic [`ZBB_SELECT_W-1:0]   ZBBSelectE,
  output logic [`BALU_CTRL_W-1:0]    BALUControlE,
  output logic                       BMUActiveE
);

  localparam int ExeW = `BSELECT_W + `ZBB_SELECT_W + `BALU_CTRL_W + 1;

  logic [`BALU_CTRL_W-1:0] baluControlD;
  logic [ExeW-1:0]         ctrlD;
  logic [ExeW-1:0]         ctrlE;                 // execute control register

  // bmu select, else funct3 for base alu ops, else add
  assign ALUSelectD   = BALUOpD ? BALUSelectD : (ALUOpD ? Funct3D : '0);
  assign baluControlD = {RotateD, MaskD, PreShiftD};
  assign ctrlD        = {BSelectD, ZBBSelectD, baluControlD, ~IllegalBitmanipInstrD};

  always_ff @(posedge clk) begin
    if (reset)
      ctrlE <= '0;
    else if (!StallE)                             // stall holds, flush ignored
      ctrlE <= FlushE ? '0 : ctrlD;
  end

  assign {BSelectE, ZBBSelectE, BALUControlE, BMUActiveE} = ctrlE;

endmodule

`default_nettype wire
